/* hw/l15_msg_pkg.sv */
`default_nettype none

package l15_msg_pkg;

    // Physical address as the L1.5 sees it, wider than the core address
    typedef logic [39:0] l15_addr_t;

    // One data word of a return message, stored big endian
    typedef logic [63:0] l15_word_t;

    // Request and return type fields of the message headers
    typedef logic [4:0] l15_rqtype_t;
    typedef logic [3:0] l15_rettype_t;

    // Interrupt type field carried inside data word 0 of an INT_RET
    typedef logic [1:0] l15_int_type_t;

    // Instruction miss request, the only request this bridge sends
    localparam l15_rqtype_t IMISS_RQ = 5'b10000;

    // Return codes that can arrive on the response side
    localparam l15_rettype_t LOAD_RET  = 4'b0000;
    localparam l15_rettype_t IFILL_RET = 4'b0001;
    localparam l15_rettype_t ST_ACK    = 4'b0100;
    localparam l15_rettype_t INT_RET   = 4'b0111;

    // Bit position of the interrupt type inside data word 0
    localparam int INT_TYPE_LSB = 16;

    // Interrupt type that releases the core from reset
    localparam l15_int_type_t INT_TYPE_RESET = 2'b01;

    // An instruction fill always returns one block of this many bytes
    localparam int BLOCK_BYTES = 32;

endpackage

`default_nettype wire

/* hw/ifill_pkg.sv */
`default_nettype none

package ifill_pkg;

    // Linear address as issued by the core fetch unit
    typedef logic [31:0] core_addr_t;

    // Little endian instruction word as handed to the core
    typedef logic [31:0] code_word_t;

    // Two code words made from one L1.5 data word
    typedef logic [63:0] code_pair_t;

    // Full 16-byte fetch window, word 0 in the low bits
    typedef logic [127:0] code_line_t;

    // Index of the 8-byte slot inside a 32-byte block
    typedef logic [1:0] window_t;

    // Position of the word currently streamed to the core
    typedef logic [1:0] word_idx_t;

    // The slot index starts at this address bit
    localparam int WINDOW_LSB = 3;

    localparam int WORDS_PER_LINE = 4;

    typedef enum logic [1:0] {
        FILL_IDLE,
        FILL_SEND,
        FILL_WAIT
    } fill_state_t;

endpackage

`default_nettype wire

/* hw/fill_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Context of one instruction fill, shared by the request and return sides
interface fill_if;

    // Slot of the fetch window inside the first block
    ifill_pkg::window_t window;

    // The window crosses a block boundary, so two requests go out
    logic split;

    // High while the request for the second block is outstanding
    logic second_pass;

    // Pulse for every instruction fill return seen on the L1.5 port
    logic fill_ret;

    // Request side owns the context and watches for the returns
    modport req (output window, output split, output second_pass, input fill_ret);

    // Return side uses the context to pick data words
    modport ret (input window, input split, input second_pass, output fill_ret);

endinterface

`default_nettype wire

/* hw/ifill_request.sv */
`timescale 1ns/1ps
`default_nettype none

module ifill_request (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     readcode_do,
    input  ifill_pkg::core_addr_t    readcode_address,
    input  logic                     header_ack,
    output l15_msg_pkg::l15_addr_t   l15_addr,
    output l15_msg_pkg::l15_rqtype_t l15_rqtype,
    output logic                     l15_val,
    fill_if.req                      fill
);

    ifill_pkg::fill_state_t state;

    // Start of the first block that holds the fetch window
    ifill_pkg::core_addr_t block_addr;

    // Slot of the captured address, taken straight from the core bus
    ifill_pkg::window_t req_window;

    // Sign extension keeps the top of the core space at the top of the L1.5 space
    function automatic l15_msg_pkg::l15_addr_t to_l15_addr(input ifill_pkg::core_addr_t a);
        to_l15_addr = l15_msg_pkg::l15_addr_t'(signed'(a));
    endfunction

    assign req_window = readcode_address[ifill_pkg::WINDOW_LSB +: $bits(ifill_pkg::window_t)];

    // Address and slot are captured with the request and only read while busy
    always_ff @(posedge clk) begin
        if (state == ifill_pkg::FILL_IDLE && readcode_do) begin
            block_addr <= readcode_address
                          & ~ifill_pkg::core_addr_t'(l15_msg_pkg::BLOCK_BYTES - 1);
            fill.window <= req_window;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state            <= ifill_pkg::FILL_IDLE;
            l15_val          <= 1'b0;
            l15_rqtype       <= '0;
            l15_addr         <= '0;
            fill.split       <= 1'b0;
            fill.second_pass <= 1'b0;
        end else begin
            case (state)
                ifill_pkg::FILL_IDLE: begin
                    // A fetch is only taken when no fill is in flight
                    if (readcode_do) begin
                        state            <= ifill_pkg::FILL_SEND;
                        fill.split       <= &req_window;
                        fill.second_pass <= 1'b0;
                    end
                end

                ifill_pkg::FILL_SEND: begin
                    // First miss request goes out for the block of the fetch address
                    l15_val    <= 1'b1;
                    l15_rqtype <= l15_msg_pkg::IMISS_RQ;
                    l15_addr   <= to_l15_addr(block_addr);
                    state      <= ifill_pkg::FILL_WAIT;
                end

                ifill_pkg::FILL_WAIT: begin
                    // The L1.5 takes the header, so the request strobe drops
                    if (l15_val && header_ack) begin
                        l15_val    <= 1'b0;
                        l15_rqtype <= '0;
                    end
                    if (fill.fill_ret) begin
                        if (fill.split && !fill.second_pass) begin
                            // Upper half of the window sits in the next block
                            l15_val          <= 1'b1;
                            l15_rqtype       <= l15_msg_pkg::IMISS_RQ;
                            l15_addr         <= to_l15_addr(block_addr
                                                + ifill_pkg::core_addr_t'(
                                                  l15_msg_pkg::BLOCK_BYTES));
                            fill.second_pass <= 1'b1;
                        end else begin
                            // Last return of the fill, the line is on its way to the core
                            state            <= ifill_pkg::FILL_IDLE;
                            fill.second_pass <= 1'b0;
                        end
                    end
                end

                default: begin
                    state <= ifill_pkg::FILL_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/l15_return_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module l15_return_unit (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      resp_val,
    input  l15_msg_pkg::l15_rettype_t returntype,
    input  l15_msg_pkg::l15_word_t    data_0,
    input  l15_msg_pkg::l15_word_t    data_1,
    input  l15_msg_pkg::l15_word_t    data_2,
    input  l15_msg_pkg::l15_word_t    data_3,
    fill_if.ret                       fill,
    output logic                      req_ack,
    output ifill_pkg::code_line_t     line,
    output logic                      line_valid,
    output logic                      core_int
);

    l15_msg_pkg::l15_word_t data_words [4];

    // Slot that supplies the upper half of the line, wrapping to word 0
    ifill_pkg::window_t hi_idx;

    ifill_pkg::code_pair_t lo_pair;
    ifill_pkg::code_pair_t hi_pair;

    logic ifill_hit;
    logic int_hit;

    // First return of a block crossing fill, which only fills the lower half
    logic first_of_split;

    function automatic ifill_pkg::code_word_t swap_bytes(input ifill_pkg::code_word_t w);
        swap_bytes = {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    // Upper half of a big endian word comes first in fetch order
    function automatic ifill_pkg::code_pair_t code_pair(input l15_msg_pkg::l15_word_t w);
        code_pair = {swap_bytes(w[31:0]), swap_bytes(w[63:32])};
    endfunction

    assign data_words[0] = data_0;
    assign data_words[1] = data_1;
    assign data_words[2] = data_2;
    assign data_words[3] = data_3;

    assign hi_idx  = fill.window + ifill_pkg::window_t'(1);
    assign lo_pair = code_pair(data_words[fill.window]);
    assign hi_pair = code_pair(data_words[hi_idx]);

    // Every response is taken in the cycle it shows up
    assign req_ack = resp_val;

    assign ifill_hit = resp_val && (returntype == l15_msg_pkg::IFILL_RET);

    // The request side only acts on this while it waits for a fill
    assign fill.fill_ret = ifill_hit;

    assign first_of_split = fill.split && !fill.second_pass;

    assign int_hit = resp_val && (returntype == l15_msg_pkg::INT_RET)
                     && (data_0[l15_msg_pkg::INT_TYPE_LSB +: $bits(l15_msg_pkg::l15_int_type_t)]
                         == l15_msg_pkg::INT_TYPE_RESET);

    // For a split fill the lower slot is word 3 of the first block and the
    // upper slot is word 0 of the second block, which the wrap of hi_idx gives
    always_ff @(posedge clk) begin
        if (ifill_hit) begin
            if (!fill.second_pass) begin
                line[63:0] <= lo_pair;
            end
            if (!first_of_split) begin
                line[127:64] <= hi_pair;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            line_valid <= 1'b0;
            core_int   <= 1'b0;
        end else begin
            // Line is complete after the single return or the second of two
            line_valid <= ifill_hit && !first_of_split;
            core_int   <= int_hit;
        end
    end

endmodule

`default_nettype wire

/* hw/code_streamer.sv */
`timescale 1ns/1ps
`default_nettype none

module code_streamer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  ifill_pkg::code_line_t line,
    input  logic                  line_valid,
    output ifill_pkg::code_word_t readcode_partial,
    output ifill_pkg::code_line_t readcode_line,
    output logic                  readcode_partial_done,
    output logic                  readcode_done
);

    // Copy of the line so the return side may move on during the stream
    ifill_pkg::code_line_t line_q;

    // Index of the word that goes out on the next edge
    ifill_pkg::word_idx_t idx;

    logic active;

    logic last_word;

    assign last_word = (idx == ifill_pkg::word_idx_t'(ifill_pkg::WORDS_PER_LINE - 1));

    always_ff @(posedge clk) begin
        if (line_valid) begin
            line_q           <= line;
            // Word 0 leaves directly from the incoming line
            readcode_partial <= line[0 +: $bits(ifill_pkg::code_word_t)];
            readcode_line    <= ifill_pkg::code_line_t'(line[0 +: $bits(ifill_pkg::code_word_t)]);
        end else if (active) begin
            readcode_partial <= line_q[idx * $bits(ifill_pkg::code_word_t)
                                       +: $bits(ifill_pkg::code_word_t)];
            // Line output grows by one word per cycle
            readcode_line[idx * $bits(ifill_pkg::code_word_t) +: $bits(ifill_pkg::code_word_t)]
                <= line_q[idx * $bits(ifill_pkg::code_word_t) +: $bits(ifill_pkg::code_word_t)];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active                <= 1'b0;
            idx                   <= '0;
            readcode_partial_done <= 1'b0;
            readcode_done         <= 1'b0;
        end else begin
            readcode_done <= 1'b0;
            if (line_valid) begin
                active                <= 1'b1;
                idx                   <= ifill_pkg::word_idx_t'(1);
                readcode_partial_done <= 1'b1;
            end else if (active) begin
                idx <= idx + ifill_pkg::word_idx_t'(1);
                if (last_word) begin
                    // The final word carries the done strobe instead
                    active                <= 1'b0;
                    readcode_partial_done <= 1'b0;
                    readcode_done         <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hw/ifill_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module ifill_bridge (
    input  logic                      clk,
    input  logic                      rst_n,

    // Requests toward the L1.5
    output l15_msg_pkg::l15_rqtype_t  transducer_l15_rqtype,
    output l15_msg_pkg::l15_addr_t    transducer_l15_address,
    output logic                      transducer_l15_val,
    output logic                      transducer_l15_req_ack,

    // Acknowledges and returns from the L1.5
    input  logic                      l15_transducer_header_ack,
    input  logic                      l15_transducer_val,
    input  l15_msg_pkg::l15_rettype_t l15_transducer_returntype,
    input  l15_msg_pkg::l15_word_t    l15_transducer_data_0,
    input  l15_msg_pkg::l15_word_t    l15_transducer_data_1,
    input  l15_msg_pkg::l15_word_t    l15_transducer_data_2,
    input  l15_msg_pkg::l15_word_t    l15_transducer_data_3,

    // Code fetch from the core
    input  logic                      request_readcode_do,
    input  ifill_pkg::core_addr_t     request_readcode_address,

    // Code words and interrupt toward the core
    output ifill_pkg::code_word_t     transducer_ao486_readcode_partial,
    output ifill_pkg::code_line_t     transducer_ao486_readcode_line,
    output logic                      transducer_ao486_request_readcode_done,
    output logic                      transducer_ao486_readcode_partial_done,
    output logic                      ao486_int
);

    fill_if fill_bus ();

    ifill_pkg::code_line_t line;
    logic                  line_valid;

    ifill_request u_request (
        .clk              (clk),
        .rst_n            (rst_n),
        .readcode_do      (request_readcode_do),
        .readcode_address (request_readcode_address),
        .header_ack       (l15_transducer_header_ack),
        .l15_addr         (transducer_l15_address),
        .l15_rqtype       (transducer_l15_rqtype),
        .l15_val          (transducer_l15_val),
        .fill             (fill_bus)
    );

    l15_return_unit u_return (
        .clk        (clk),
        .rst_n      (rst_n),
        .resp_val   (l15_transducer_val),
        .returntype (l15_transducer_returntype),
        .data_0     (l15_transducer_data_0),
        .data_1     (l15_transducer_data_1),
        .data_2     (l15_transducer_data_2),
        .data_3     (l15_transducer_data_3),
        .fill       (fill_bus),
        .req_ack    (transducer_l15_req_ack),
        .line       (line),
        .line_valid (line_valid),
        .core_int   (ao486_int)
    );

    code_streamer u_streamer (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .line                  (line),
        .line_valid            (line_valid),
        .readcode_partial      (transducer_ao486_readcode_partial),
        .readcode_line         (transducer_ao486_readcode_line),
        .readcode_partial_done (transducer_ao486_readcode_partial_done),
        .readcode_done         (transducer_ao486_request_readcode_done)
    );

endmodule

`default_nettype wire

/* bench/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

// Free running clock with a 4 ns period
module tb_clock (
    output logic clk
);

    initial clk = 1'b0;

    always #2 clk = ~clk;

endmodule

`default_nettype wire

/* bench/ifill_bridge_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module ifill_bridge_assertions (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     val,
    input logic                     header_ack,
    input l15_msg_pkg::l15_rqtype_t rqtype,
    input logic                     done
);

    // The request stays up until the L1.5 takes its header
    val_held: assert property (@(posedge clk) disable iff (!rst_n)
                               (val && !header_ack) |=> val)
        else $error("request valid dropped before header acknowledge");

    // Only instruction miss requests ever leave the bridge
    rqtype_imiss: assert property (@(posedge clk) disable iff (!rst_n)
                                   val |-> (rqtype == l15_msg_pkg::IMISS_RQ))
        else $error("request type is not an instruction miss while valid");

    // One done strobe per line, never two cycles in a row
    done_single: assert property (@(posedge clk) disable iff (!rst_n)
                                  done |=> !done)
        else $error("readcode done held for two cycles");

endmodule

bind ifill_bridge ifill_bridge_assertions u_assertions (
    .clk        (clk),
    .rst_n      (rst_n),
    .val        (transducer_l15_val),
    .header_ack (l15_transducer_header_ack),
    .rqtype     (transducer_l15_rqtype),
    .done       (transducer_ao486_request_readcode_done)
);

`default_nettype wire

/* bench/ifill_bridge_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ifill_bridge_tb;

    localparam int NUM_ROWS = 6;

    // A row may need two fill passes, each one well inside forty cycles
    localparam int CYCLE_LIMIT = 2 * NUM_ROWS * 40;

    logic                      clk;
    logic                      rst_n;
    l15_msg_pkg::l15_rqtype_t  rqtype;
    l15_msg_pkg::l15_addr_t    address;
    logic                      req_val;
    logic                      req_ack;
    logic                      header_ack;
    logic                      resp_val;
    l15_msg_pkg::l15_rettype_t returntype;
    l15_msg_pkg::l15_word_t    resp_data [4];
    logic                      readcode_do;
    ifill_pkg::core_addr_t     readcode_address;
    ifill_pkg::code_word_t     partial;
    ifill_pkg::code_line_t     line_out;
    logic                      done;
    logic                      partial_done;
    logic                      core_int;

    // Stimulus table with one fetch per row and two returns of four words each
    ifill_pkg::core_addr_t  row_addr [NUM_ROWS];
    l15_msg_pkg::l15_word_t row_data [NUM_ROWS][2][4];
    ifill_pkg::code_line_t  row_line [NUM_ROWS];

    int seed = 32'h3ca4;
    int error_count = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int cycle_count = 0;

    tb_clock u_clock (.clk(clk));

    ifill_bridge UUT (
        .clk                                    (clk),
        .rst_n                                  (rst_n),
        .transducer_l15_rqtype                  (rqtype),
        .transducer_l15_address                 (address),
        .transducer_l15_val                     (req_val),
        .transducer_l15_req_ack                 (req_ack),
        .l15_transducer_header_ack              (header_ack),
        .l15_transducer_val                     (resp_val),
        .l15_transducer_returntype              (returntype),
        .l15_transducer_data_0                  (resp_data[0]),
        .l15_transducer_data_1                  (resp_data[1]),
        .l15_transducer_data_2                  (resp_data[2]),
        .l15_transducer_data_3                  (resp_data[3]),
        .request_readcode_do                    (readcode_do),
        .request_readcode_address               (readcode_address),
        .transducer_ao486_readcode_partial      (partial),
        .transducer_ao486_readcode_line         (line_out),
        .transducer_ao486_request_readcode_done (done),
        .transducer_ao486_readcode_partial_done (partial_done),
        .ao486_int                              (core_int)
    );

    task automatic check_addr(input string name, input l15_msg_pkg::l15_addr_t got,
                              input l15_msg_pkg::l15_addr_t exp);
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_rqtype(input string name, input l15_msg_pkg::l15_rqtype_t got,
                                input l15_msg_pkg::l15_rqtype_t exp);
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input ifill_pkg::code_word_t got,
                              input ifill_pkg::code_word_t exp);
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_line(input string name, input ifill_pkg::code_line_t got,
                              input ifill_pkg::code_line_t exp);
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // Block start sign extended to 40 bits and moved one block on for the second pass
    function automatic l15_msg_pkg::l15_addr_t block_address(input ifill_pkg::core_addr_t a,
                                                             input logic second);
        l15_msg_pkg::l15_addr_t blk;
        blk = {{8{a[31]}}, a[31:5], 5'b00000};
        if (second) begin
            blk = blk + 40'd32;
        end
        return blk;
    endfunction

    // Even code words come from the upper half of their data word, bytes reversed
    function automatic ifill_pkg::code_line_t expected_line(input l15_msg_pkg::l15_word_t lo,
                                                            input l15_msg_pkg::l15_word_t hi);
        ifill_pkg::code_line_t res;
        l15_msg_pkg::l15_word_t src;
        for (int k = 0; k < 4; k++) begin
            src = (k < 2) ? lo : hi;
            for (int j = 0; j < 4; j++) begin
                res[k * 32 + j * 8 +: 8] = src[((k % 2 == 0) ? 32 : 0) + (3 - j) * 8 +: 8];
            end
        end
        return res;
    endfunction

    function automatic int random_delay();
        return 1 + int'($unsigned($random(seed)) % 32'd4);
    endfunction

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (error_count != errors_before) begin
            tests_failed++;
            $display("test %0d %s: FAIL", tests_run, name);
        end else begin
            $display("test %0d %s: ok", tests_run, name);
        end
    endtask

    // Plays the L1.5 for one miss request from the header up to the fill return
    task automatic serve_pass(input int r, input logic second);
        int delay;
        @(negedge clk);
        while (!req_val) begin
            @(negedge clk);
        end
        check_addr("transducer_l15_address", address, block_address(row_addr[r], second));
        check_rqtype("transducer_l15_rqtype", rqtype, l15_msg_pkg::IMISS_RQ);
        delay = random_delay();
        // A fetch that shows up during the fill has to be dropped
        for (int i = 0; i < delay; i++) begin
            @(posedge clk);
            readcode_do      <= (i == 0) && !second;
            readcode_address <= ~row_addr[r];
        end
        @(posedge clk);
        readcode_do <= 1'b0;
        header_ack  <= 1'b1;
        @(posedge clk);
        header_ack <= 1'b0;
        @(negedge clk);
        check_bit("transducer_l15_val", req_val, 1'b0);
        repeat (random_delay()) @(posedge clk);
        resp_val   <= 1'b1;
        returntype <= l15_msg_pkg::IFILL_RET;
        for (int i = 0; i < 4; i++) begin
            resp_data[i] <= row_data[r][second][i];
        end
        @(negedge clk);
        check_bit("transducer_l15_req_ack", req_ack, 1'b1);
        @(posedge clk);
        resp_val <= 1'b0;
    endtask

    // Checks four words on four cycles while the line output grows from the low end
    task automatic check_stream(input ifill_pkg::code_line_t exp);
        ifill_pkg::code_line_t mask;
        @(negedge clk);
        while (!partial_done) begin
            @(negedge clk);
        end
        for (int k = 0; k < 4; k++) begin
            if (k > 0) begin
                @(negedge clk);
            end
            mask = {128{1'b1}} >> (32 * (3 - k));
            check_word("transducer_ao486_readcode_partial", partial, exp[k * 32 +: 32]);
            check_line("transducer_ao486_readcode_line", line_out, exp & mask);
            check_bit("transducer_ao486_readcode_partial_done", partial_done, k < 3);
            check_bit("transducer_ao486_request_readcode_done", done, k == 3);
        end
        @(negedge clk);
        check_bit("transducer_ao486_request_readcode_done", done, 1'b0);
        check_bit("transducer_l15_val", req_val, 1'b0);
    endtask

    // Sends a non fill return that is acknowledged at once and may raise an interrupt
    task automatic send_other(input l15_msg_pkg::l15_rettype_t rt,
                              input l15_msg_pkg::l15_int_type_t int_type, input logic exp_int);
        @(posedge clk);
        resp_val     <= 1'b1;
        returntype   <= rt;
        resp_data[0] <= l15_msg_pkg::l15_word_t'(int_type) << l15_msg_pkg::INT_TYPE_LSB;
        @(negedge clk);
        check_bit("transducer_l15_req_ack", req_ack, 1'b1);
        check_bit("ao486_int", core_int, 1'b0);
        @(posedge clk);
        resp_val <= 1'b0;
        @(negedge clk);
        check_bit("ao486_int", core_int, exp_int);
        repeat (4) begin
            @(negedge clk);
            check_bit("ao486_int", core_int, 1'b0);
            check_bit("transducer_ao486_readcode_partial_done", partial_done, 1'b0);
            check_bit("transducer_l15_val", req_val, 1'b0);
        end
    endtask

    initial begin
        int errors_before;
        rst_n            <= 1'b0;
        header_ack       <= 1'b0;
        resp_val         <= 1'b0;
        returntype       <= l15_msg_pkg::LOAD_RET;
        readcode_do      <= 1'b0;
        readcode_address <= '0;
        for (int i = 0; i < 4; i++) begin
            resp_data[i] <= '0;
        end

        // The rows cover windows 0 to 3 and two addresses in the upper half of the core space
        row_addr = '{32'h0000_1000, 32'h0000_2048, 32'h8000_3150,
                     32'h0000_4018, 32'hffff_ff5c, 32'h7fff_00a3};
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int p = 0; p < 2; p++) begin
                for (int i = 0; i < 4; i++) begin
                    row_data[r][p][i] = {$random(seed), $random(seed)};
                end
            end
            if (&row_addr[r][4:3]) begin
                row_line[r] = expected_line(row_data[r][0][3], row_data[r][1][0]);
            end else begin
                row_line[r] = expected_line(row_data[r][0][row_addr[r][4:3]],
                                            row_data[r][0][row_addr[r][4:3] + 2'd1]);
            end
        end

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        errors_before = error_count;
        @(negedge clk);
        check_bit("transducer_l15_val", req_val, 1'b0);
        check_rqtype("transducer_l15_rqtype", rqtype, '0);
        check_addr("transducer_l15_address", address, '0);
        check_bit("transducer_ao486_request_readcode_done", done, 1'b0);
        check_bit("transducer_ao486_readcode_partial_done", partial_done, 1'b0);
        check_bit("ao486_int", core_int, 1'b0);
        finish_test("values after reset", errors_before);

        for (int r = 0; r < NUM_ROWS; r++) begin
            errors_before = error_count;
            @(posedge clk);
            readcode_do      <= 1'b1;
            readcode_address <= row_addr[r];
            @(posedge clk);
            readcode_do <= 1'b0;
            serve_pass(r, 1'b0);
            if (&row_addr[r][4:3]) begin
                serve_pass(r, 1'b1);
            end
            check_stream(row_line[r]);
            finish_test($sformatf("fill at %h", row_addr[r]), errors_before);
        end

        errors_before = error_count;
        send_other(l15_msg_pkg::INT_RET, l15_msg_pkg::INT_TYPE_RESET, 1'b1);
        finish_test("reset interrupt", errors_before);
        errors_before = error_count;
        send_other(l15_msg_pkg::INT_RET, l15_msg_pkg::l15_int_type_t'(2'b10), 1'b0);
        finish_test("other interrupt type", errors_before);
        errors_before = error_count;
        send_other(l15_msg_pkg::LOAD_RET, l15_msg_pkg::INT_TYPE_RESET, 1'b0);
        finish_test("load return ignored", errors_before);
        errors_before = error_count;
        send_other(l15_msg_pkg::ST_ACK, l15_msg_pkg::INT_TYPE_RESET, 1'b0);
        finish_test("store ack ignored", errors_before);

        $display("%0d tests run, %0d failed, %0d check errors",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Ends a run that hangs on a handshake the DUT never gives
    initial begin
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, the DUT stopped responding", cycle_count);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* ifill_bridge.f */
hw/l15_msg_pkg.sv
hw/ifill_pkg.sv
hw/fill_if.sv
hw/ifill_request.sv
hw/l15_return_unit.sv
hw/code_streamer.sv
hw/ifill_bridge.sv
bench/tb_clock.sv
bench/ifill_bridge_assertions.sv
bench/ifill_bridge_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile the testbench and the bridge with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -j 0 \
    -f ifill_bridge.f --top-module ifill_bridge_tb > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/Vifill_bridge_tb > sim.log 2>&1

grep -q "^Simulation passed$" sim.log \
    && { echo "PASS"; exit 0; } \
    || { echo "FAIL, see sim.log"; exit 1; }
